// ==== logic/cpri_rx_pkg.sv ====
package cpri_rx_pkg;

    // ------------------------------------------------------------------------
    // widths that carry a meaning
    // ------------------------------------------------------------------------

    // one cpri payload word
    typedef logic [63:0]  word_t;

    // word address inside a chip frame, 0 to 90 in use
    typedef logic [6:0]   waddr_t;

    // frame slot index into the ram
    typedef logic [1:0]   slot_t;

    // slot index plus wrap bit
    typedef logic [2:0]   slot_ptr_t;

    // fft agc value
    typedef logic [15:0]  agc_t;

    // header words 3..0 as one vector
    typedef logic [255:0] hdr_t;

    // agc, shift, then header words 3..0 from the top down
    typedef logic [335:0] info_t;

    // ------------------------------------------------------------------------
    // frame layout
    // ------------------------------------------------------------------------

    // frames held at once
    localparam int     SLOT_NUM      = 4;

    // header window
    localparam waddr_t HDR_FIRST     = 7'd3;
    localparam waddr_t HDR_LAST      = 7'd6;

    // payload window, info record packed on its first word
    localparam waddr_t PAYLOAD_FIRST = 7'd7;
    localparam waddr_t PAYLOAD_LAST  = 7'd90;

    // issue to data, in rd_clk cycles
    localparam int     READ_LATENCY  = 2;

endpackage

// ==== logic/cpri_hdr_capture.sv ====
`timescale 1ns/1ps

module cpri_hdr_capture import cpri_rx_pkg::*; (
    input  logic   wr_clk,
    input  logic   wr_rst,
    input  logic   i_wen,
    input  waddr_t i_waddr,
    input  word_t  i_wdata,
    input  agc_t   i_fft_agc,
    input  word_t  i_fft_shift,
    output info_t  o_info
);

    word_t  hdr_q [HDR_LAST - HDR_FIRST + 1];
    waddr_t hdr_off;
    logic   hdr_hit;
    info_t  info_q;

    // ------------------------------------------------------------------------
    // header words 3 to 6
    // ------------------------------------------------------------------------

    // position inside the header window
    assign hdr_off = i_waddr - HDR_FIRST;
    assign hdr_hit = i_wen && (i_waddr >= HDR_FIRST) && (i_waddr <= HDR_LAST);

    always_ff @(posedge wr_clk) begin
        if (hdr_hit) begin
            hdr_q[hdr_off[1:0]] <= i_wdata;
        end
    end

    // ------------------------------------------------------------------------
    // info record
    // ------------------------------------------------------------------------

    // agc and shift sampled with the first payload word
    always_ff @(posedge wr_clk) begin
        if (i_wen && (i_waddr == PAYLOAD_FIRST)) begin
            info_q <= {i_fft_agc, i_fft_shift, hdr_q[3], hdr_q[2], hdr_q[1], hdr_q[0]};
        end
    end

    assign o_info = info_q;

    // frame never runs past the payload window
    a_waddr_range: assert property (
        @(posedge wr_clk) disable iff (wr_rst) i_wen |-> (i_waddr <= PAYLOAD_LAST)
    );

endmodule

// ==== logic/cpri_frame_ram.sv ====
`timescale 1ns/1ps

module cpri_frame_ram import cpri_rx_pkg::*; (
    input  logic   wr_clk,
    input  logic   i_wen,
    input  slot_t  i_wslot,
    input  waddr_t i_waddr,
    input  word_t  i_wdata,
    input  logic   rd_clk,
    input  slot_t  i_rslot,
    input  waddr_t i_raddr,
    output word_t  o_rdata
);

    // one 128 word page per frame slot
    word_t  mem [SLOT_NUM][1 << $bits(waddr_t)];

    slot_t  rslot_q;
    waddr_t raddr_q;
    word_t  rdata_q;

    // ------------------------------------------------------------------------
    // write port
    // ------------------------------------------------------------------------

    always_ff @(posedge wr_clk) begin
        if (i_wen) begin
            mem[i_wslot][i_waddr] <= i_wdata;
        end
    end

    // ------------------------------------------------------------------------
    // read port
    // ------------------------------------------------------------------------

    // stage 1, address register
    always_ff @(posedge rd_clk) begin
        rslot_q <= i_rslot;
        raddr_q <= i_raddr;
    end

    // stage 2, output register
    always_ff @(posedge rd_clk) begin
        rdata_q <= mem[rslot_q][raddr_q];
    end

    assign o_rdata = rdata_q;

endmodule

// ==== logic/cpri_frame_ring.sv ====
`timescale 1ns/1ps

module cpri_frame_ring import cpri_rx_pkg::*; (
    input  logic   wr_clk,
    input  logic   wr_rst,
    input  logic   rd_clk,
    input  logic   rd_rst,
    input  logic   i_wen,
    input  waddr_t i_waddr,
    input  word_t  i_wdata,
    input  logic   i_wlast,
    input  info_t  i_info,
    input  waddr_t i_raddr,
    input  logic   i_frame_done,
    output logic   o_tready,
    output logic   o_frame_vld,
    output info_t  o_rd_info,
    output word_t  o_rd_data
);

    function automatic slot_ptr_t bin2gray(input slot_ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    function automatic slot_ptr_t gray2bin(input slot_ptr_t gray);
        slot_ptr_t bin;
        bin[$bits(slot_ptr_t)-1] = gray[$bits(slot_ptr_t)-1];
        for (int i = $bits(slot_ptr_t) - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    slot_ptr_t wr_ptr;
    slot_ptr_t wr_ptr_nxt;
    slot_ptr_t wr_gray;
    slot_ptr_t rd_gray_s1;
    slot_ptr_t rd_gray_s2;
    slot_ptr_t rd_ptr_wr;
    slot_ptr_t wr_free;
    slot_t     wr_slot;
    slot_ptr_t rd_ptr;
    slot_ptr_t rd_ptr_nxt;
    slot_ptr_t rd_gray;
    slot_ptr_t wr_gray_s1;
    slot_ptr_t wr_gray_s2;
    slot_t     rd_slot;
    info_t     info_mem [SLOT_NUM];

    // ------------------------------------------------------------------------
    // wr_clk side
    // ------------------------------------------------------------------------

    assign wr_ptr_nxt = wr_ptr + 3'd1;
    assign wr_slot    = wr_ptr[$bits(slot_t)-1:0];

    // frame commit on the last word
    always_ff @(posedge wr_clk) begin
        if (wr_rst) begin
            wr_ptr  <= '0;
            wr_gray <= '0;
        end else if (i_wlast) begin
            wr_ptr  <= wr_ptr_nxt;
            wr_gray <= bin2gray(wr_ptr_nxt);
        end
    end

    // entry lands on the same edge as the pointer, two sync flops ahead of the reader
    always_ff @(posedge wr_clk) begin
        if (i_wlast) begin
            info_mem[wr_slot] <= i_info;
        end
    end

    // read pointer into wr_clk
    always_ff @(posedge wr_clk) begin
        if (wr_rst) begin
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
        end else begin
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
        end
    end

    assign rd_ptr_wr = gray2bin(rd_gray_s2);
    assign wr_free   = slot_ptr_t'(SLOT_NUM) - (wr_ptr - rd_ptr_wr);
    assign o_tready  = (wr_free != '0);

    // ------------------------------------------------------------------------
    // rd_clk side
    // ------------------------------------------------------------------------

    assign rd_ptr_nxt = rd_ptr + 3'd1;
    assign rd_slot    = rd_ptr[$bits(slot_t)-1:0];

    always_ff @(posedge rd_clk) begin
        if (rd_rst) begin
            rd_ptr  <= '0;
            rd_gray <= '0;
        end else if (i_frame_done) begin
            rd_ptr  <= rd_ptr_nxt;
            rd_gray <= bin2gray(rd_ptr_nxt);
        end
    end

    // write pointer into rd_clk
    always_ff @(posedge rd_clk) begin
        if (rd_rst) begin
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
        end else begin
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
        end
    end

    // gray codes match only when the ring is empty
    assign o_frame_vld = (rd_gray != wr_gray_s2);
    assign o_rd_info   = info_mem[rd_slot];

    cpri_frame_ram u_frame_ram (
        .wr_clk  (wr_clk),
        .i_wen   (i_wen),
        .i_wslot (wr_slot),
        .i_waddr (i_waddr),
        .i_wdata (i_wdata),
        .rd_clk  (rd_clk),
        .i_rslot (rd_slot),
        .i_raddr (i_raddr),
        .o_rdata (o_rd_data)
    );

    // writer respects o_tready, so no frame closes into a full ring
    a_no_commit_full: assert property (
        @(posedge wr_clk) disable iff (wr_rst) i_wlast |-> (wr_free != '0)
    );

    // reader only releases a slot that holds a frame
    a_done_vld: assert property (
        @(posedge rd_clk) disable iff (rd_rst) i_frame_done |-> o_frame_vld
    );

endmodule

// ==== logic/cpri_rx_reader.sv ====
`timescale 1ns/1ps

module cpri_rx_reader import cpri_rx_pkg::*; (
    input  logic   rd_clk,
    input  logic   rd_rst,
    input  logic   i_frame_vld,
    input  logic   i_rready,
    input  info_t  i_rd_info,
    output waddr_t o_raddr,
    output logic   o_frame_done,
    output logic   o_tvalid,
    output waddr_t o_iq_raddr,
    output hdr_t   o_rx_info,
    output agc_t   o_fft_agc,
    output word_t  o_fft_shift
);

    logic                    active_q;
    logic                    issue;
    waddr_t                  raddr_q;
    logic [READ_LATENCY-1:0] vld_pipe;
    waddr_t                  addr_pipe [READ_LATENCY];
    info_t                   info_cap;
    info_t                   info_out;

    // ------------------------------------------------------------------------
    // issue and address walk
    // ------------------------------------------------------------------------

    // frame valid seen one cycle late
    always_ff @(posedge rd_clk) begin
        if (rd_rst) begin
            active_q <= 1'b0;
        end else begin
            active_q <= i_frame_vld;
        end
    end

    assign issue = active_q && i_frame_vld && i_rready;

    // 7..90 then back to 7
    always_ff @(posedge rd_clk) begin
        if (rd_rst) begin
            raddr_q <= PAYLOAD_FIRST;
        end else if (issue) begin
            raddr_q <= (raddr_q == PAYLOAD_LAST) ? PAYLOAD_FIRST : raddr_q + 7'd1;
        end
    end

    assign o_raddr      = raddr_q;
    assign o_frame_done = issue && (raddr_q == PAYLOAD_LAST);

    // ------------------------------------------------------------------------
    // pipeline matched to the ram
    // ------------------------------------------------------------------------

    always_ff @(posedge rd_clk) begin
        if (rd_rst) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[READ_LATENCY-2:0], issue};
        end
    end

    always_ff @(posedge rd_clk) begin
        addr_pipe[0] <= raddr_q;
        for (int i = 1; i < READ_LATENCY; i++) begin
            addr_pipe[i] <= addr_pipe[i-1];
        end
    end

    // record taken at the first issue of a frame
    // moves to the output together with word 7 so the old frame's tail keeps its own record
    always_ff @(posedge rd_clk) begin
        if (issue && (raddr_q == PAYLOAD_FIRST)) begin
            info_cap <= i_rd_info;
        end
        if (vld_pipe[READ_LATENCY-2] && (addr_pipe[READ_LATENCY-2] == PAYLOAD_FIRST)) begin
            info_out <= info_cap;
        end
    end

    assign o_tvalid   = vld_pipe[READ_LATENCY-1];
    assign o_iq_raddr = addr_pipe[READ_LATENCY-1];
    assign {o_fft_agc, o_fft_shift, o_rx_info} = info_out;

    // reset flushes words in flight
    a_tvalid_rst: assert property (@(posedge rd_clk) rd_rst |=> !o_tvalid);

endmodule

// ==== logic/cpri_rx_gen.sv ====
`timescale 1ns/1ps

module cpri_rx_gen import cpri_rx_pkg::*; (
    input  logic   wr_clk,
    input  logic   wr_rst,
    input  logic   rd_clk,
    input  logic   rd_rst,
    input  logic   i_cpri_wen,
    input  waddr_t i_cpri_waddr,
    input  word_t  i_cpri_wdata,
    input  logic   i_cpri_wlast,
    input  agc_t   i_fft_agc,
    input  word_t  i_fft_shift,
    input  logic   i_rready,
    output agc_t   o_fft_agc,
    output word_t  o_fft_shift,
    output logic   o_tvalid,
    output logic   o_tready,
    output hdr_t   o_rx_info,
    output waddr_t o_iq_raddr,
    output word_t  o_iq_rx_data
);

    info_t  wr_info;
    info_t  rd_info;
    waddr_t rd_addr;
    logic   frame_vld;
    logic   frame_done;

    // ------------------------------------------------------------------------
    // wr_clk header capture
    // ------------------------------------------------------------------------

    cpri_hdr_capture u_hdr_capture (
        .wr_clk      (wr_clk),
        .wr_rst      (wr_rst),
        .i_wen       (i_cpri_wen),
        .i_waddr     (i_cpri_waddr),
        .i_wdata     (i_cpri_wdata),
        .i_fft_agc   (i_fft_agc),
        .i_fft_shift (i_fft_shift),
        .o_info      (wr_info)
    );

    // ------------------------------------------------------------------------
    // four slot frame ring, ram data goes straight out
    // ------------------------------------------------------------------------

    cpri_frame_ring u_frame_ring (
        .wr_clk       (wr_clk),
        .wr_rst       (wr_rst),
        .rd_clk       (rd_clk),
        .rd_rst       (rd_rst),
        .i_wen        (i_cpri_wen),
        .i_waddr      (i_cpri_waddr),
        .i_wdata      (i_cpri_wdata),
        .i_wlast      (i_cpri_wlast),
        .i_info       (wr_info),
        .i_raddr      (rd_addr),
        .i_frame_done (frame_done),
        .o_tready     (o_tready),
        .o_frame_vld  (frame_vld),
        .o_rd_info    (rd_info),
        .o_rd_data    (o_iq_rx_data)
    );

    // ------------------------------------------------------------------------
    // rd_clk sequencer
    // ------------------------------------------------------------------------

    cpri_rx_reader u_rx_reader (
        .rd_clk       (rd_clk),
        .rd_rst       (rd_rst),
        .i_frame_vld  (frame_vld),
        .i_rready     (i_rready),
        .i_rd_info    (rd_info),
        .o_raddr      (rd_addr),
        .o_frame_done (frame_done),
        .o_tvalid     (o_tvalid),
        .o_iq_raddr   (o_iq_raddr),
        .o_rx_info    (o_rx_info),
        .o_fft_agc    (o_fft_agc),
        .o_fft_shift  (o_fft_shift)
    );

endmodule

// ==== dv/cpri_rx_tb.sv ====
`timescale 1ns/1ps

module cpri_rx_tb import cpri_rx_pkg::*; ();

    // ------------------------------------------------------------------------
    // run length
    // ------------------------------------------------------------------------

    localparam int     FRAMES         = 40;
    localparam waddr_t LAST_IDX       = PAYLOAD_LAST - PAYLOAD_FIRST;
    localparam int     TIMEOUT_CYCLES = FRAMES * (int'(LAST_IDX) + 1) * 4 + 2000;

    // one expected frame with payload words 7..90 at index 0..83
    typedef struct packed {
        word_t [LAST_IDX:0] words;
        hdr_t               hdr;
        agc_t               agc;
        word_t              shift;
    } frame_t;

    logic   wr_clk;
    logic   rd_clk;
    logic   wr_rst;
    logic   rd_rst;
    logic   i_cpri_wen;
    waddr_t i_cpri_waddr;
    word_t  i_cpri_wdata;
    logic   i_cpri_wlast;
    agc_t   i_fft_agc;
    word_t  i_fft_shift;
    logic   i_rready;
    agc_t   o_fft_agc;
    word_t  o_fft_shift;
    logic   o_tvalid;
    logic   o_tready;
    hdr_t   o_rx_info;
    waddr_t o_iq_raddr;
    word_t  o_iq_rx_data;

    frame_t      exp_frames [$];
    frame_t      cur_frame;
    waddr_t      word_idx;
    int          frames_seen;
    int          cycle_cnt;
    logic        hold_ready;
    logic [31:0] rng_state;
    logic [31:0] ready_draw;

    cpri_rx_gen i_dut (
        .wr_clk       (wr_clk),
        .wr_rst       (wr_rst),
        .rd_clk       (rd_clk),
        .rd_rst       (rd_rst),
        .i_cpri_wen   (i_cpri_wen),
        .i_cpri_waddr (i_cpri_waddr),
        .i_cpri_wdata (i_cpri_wdata),
        .i_cpri_wlast (i_cpri_wlast),
        .i_fft_agc    (i_fft_agc),
        .i_fft_shift  (i_fft_shift),
        .i_rready     (i_rready),
        .o_fft_agc    (o_fft_agc),
        .o_fft_shift  (o_fft_shift),
        .o_tvalid     (o_tvalid),
        .o_tready     (o_tready),
        .o_rx_info    (o_rx_info),
        .o_iq_raddr   (o_iq_raddr),
        .o_iq_rx_data (o_iq_rx_data)
    );

    // 40 ns read clock and 28 ns write clock
    always #20 rd_clk = ~rd_clk;
    always #14 wr_clk = ~wr_clk;

    // ------------------------------------------------------------------------
    // random source and failure handling
    // ------------------------------------------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input word_t got_data, input waddr_t got_addr,
                              input word_t exp_data, input waddr_t exp_addr);
        if (got_addr !== exp_addr || got_data !== exp_data) begin
            $display("** Error at %0t ns: word @%0d = %h, expected @%0d = %h",
                     $time, got_addr, got_data, exp_addr, exp_data);
            abort_run();
        end
    endtask

    task automatic check_info(input hdr_t got_hdr, input agc_t got_agc, input word_t got_shift,
                              input hdr_t exp_hdr, input agc_t exp_agc, input word_t exp_shift);
        if (got_hdr !== exp_hdr || got_agc !== exp_agc || got_shift !== exp_shift) begin
            $display("** Error at %0t ns: info hdr %h agc %h shift %h, expected %h %h %h",
                     $time, got_hdr, got_agc, got_shift, exp_hdr, exp_agc, exp_shift);
            abort_run();
        end
    endtask

    // ------------------------------------------------------------------------
    // write side driver and frame model
    // ------------------------------------------------------------------------

    // one frame over addresses 0..90 with fresh agc and shift on every word
    task automatic write_frame();
        frame_t      fr;
        word_t       hw [4];
        word_t       data;
        logic [31:0] r;
        waddr_t      a;
        // wait for a free slot
        while (!o_tready) begin
            @(negedge wr_clk);
        end
        for (a = '0; a <= PAYLOAD_LAST; a++) begin
            data         = {rand32(), rand32()};
            r            = rand32();
            i_cpri_wen   = 1'b1;
            i_cpri_waddr = a;
            i_cpri_wdata = data;
            i_cpri_wlast = (a == PAYLOAD_LAST);
            i_fft_agc    = r[15:0];
            i_fft_shift  = {rand32(), rand32()};
            if (a >= HDR_FIRST && a <= HDR_LAST) begin
                hw[slot_t'(a - HDR_FIRST)] = data;
            end
            // agc and shift count only at the first payload word
            if (a == PAYLOAD_FIRST) begin
                fr.agc   = i_fft_agc;
                fr.shift = i_fft_shift;
            end
            if (a >= PAYLOAD_FIRST) begin
                fr.words[a - PAYLOAD_FIRST] = data;
            end
            if (a == PAYLOAD_LAST) begin
                fr.hdr = {hw[3], hw[2], hw[1], hw[0]};
                exp_frames.push_back(fr);
            end
            @(negedge wr_clk);
        end
        i_cpri_wen   = 1'b0;
        i_cpri_wlast = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // read side ready pattern, checker, timeout
    // ------------------------------------------------------------------------

    // ready high about three cycles out of four
    always @(negedge rd_clk) begin
        if (rd_rst || hold_ready) begin
            i_rready <= 1'b0;
        end else begin
            ready_draw = rand32();
            i_rready <= (ready_draw[1:0] != 2'b00);
        end
    end

    // compare every o_tvalid word with the head of the model
    always @(negedge rd_clk) begin
        if (!rd_rst && o_tvalid) begin
            if (exp_frames.size() == 0) begin
                $display("o_tvalid went high with no frame left in the model at %0t ns", $time);
                abort_run();
            end else begin
                cur_frame = exp_frames[0];
                check_word(o_iq_rx_data, o_iq_raddr, cur_frame.words[word_idx],
                           PAYLOAD_FIRST + word_idx);
                check_info(o_rx_info, o_fft_agc, o_fft_shift,
                           cur_frame.hdr, cur_frame.agc, cur_frame.shift);
                if (word_idx == LAST_IDX) begin
                    word_idx = '0;
                    exp_frames.delete(0);
                    frames_seen++;
                end else begin
                    word_idx = word_idx + 7'd1;
                end
            end
        end
    end

    always @(posedge rd_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d rd_clk cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------

    initial begin
        logic [31:0] gap;
        wr_clk       = 1'b0;
        rd_clk       = 1'b0;
        wr_rst       = 1'b1;
        rd_rst       = 1'b1;
        i_cpri_wen   = 1'b0;
        i_cpri_waddr = '0;
        i_cpri_wdata = '0;
        i_cpri_wlast = 1'b0;
        i_fft_agc    = '0;
        i_fft_shift  = '0;
        i_rready     = 1'b0;
        hold_ready   = 1'b1;
        rng_state    = 32'd89043;
        word_idx     = '0;
        frames_seen  = 0;
        cycle_cnt    = 0;
        // 16 cycles of reset in each domain
        fork
            begin
                repeat (16) @(negedge wr_clk);
                wr_rst = 1'b0;
            end
            begin
                repeat (16) @(negedge rd_clk);
                rd_rst = 1'b0;
            end
        join
        @(negedge rd_clk);
        check_flag(o_tvalid, 1'b0, "o_tvalid after reset");
        @(negedge wr_clk);
        check_flag(o_tready, 1'b1, "o_tready after reset");
        // fill all slots with the reader stalled
        repeat (SLOT_NUM) write_frame();
        check_flag(o_tready, 1'b0, "o_tready with every slot full");
        hold_ready = 1'b0;
        while (!o_tready) begin
            @(negedge wr_clk);
        end
        // rest of the frames with random idle gaps
        repeat (FRAMES - SLOT_NUM) begin
            gap = rand32();
            repeat (gap[2:0]) @(negedge wr_clk);
            write_frame();
        end
        while (frames_seen < FRAMES) begin
            @(negedge rd_clk);
        end
        // catch stray words after the last frame
        repeat (8) @(negedge rd_clk);
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== src.f ====
logic/cpri_rx_pkg.sv
logic/cpri_hdr_capture.sv
logic/cpri_frame_ram.sv
logic/cpri_frame_ring.sv
logic/cpri_rx_reader.sv
logic/cpri_rx_gen.sv
dv/cpri_rx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the cpri_rx testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module cpri_rx_tb \
    -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out="$(./obj_dir/Vcpri_rx_tb 2>&1)"
sim_status=$?
echo "${sim_out}"

if [ ${sim_status} -ne 0 ]; then
    echo "simulation exited with status ${sim_status}"
    exit 1
fi

if echo "${sim_out}" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1
